// File: decode_issue_top.f
+incdir+include
src/decode_pkg.sv
src/decode_basic.sv
src/reg_file.sv
src/alu_pipe.sv
src/mul_pipe.sv
src/writeback_arbiter.sv
src/decode_issue_top.sv
verification/tb_clock.sv
verification/decode_issue_tb.sv

// File: verification/decode_issue_tb.sv
/*
 * Testbench for the decode and issue slice
 * Directed and random program, golden register model, commit checker
 */

`timescale 1ns/1ps
`include "decode_params.svh"

module decode_issue_tb;

  localparam int          MAX_INST = 160;
  localparam int          N_RANDOM = 96;
  localparam logic [31:0] PC_BASE  = 32'h0000_1000;
  localparam logic [31:0] SEED     = 32'h5ea86653;

  logic                  clk, rst, inst_val, inst_rdy, commit_val, commit_rdy;
  decode_pkg::pc_t       inst_pc, commit_pc;
  decode_pkg::inst_t     inst;
  decode_pkg::reg_addr_t commit_waddr;
  decode_pkg::data_t     commit_data;

  // Program and expectations indexed by (pc - PC_BASE) / 4
  decode_pkg::inst_t     prog      [MAX_INST];
  bit                    exp_legal [MAX_INST];
  decode_pkg::reg_addr_t exp_waddr [MAX_INST];
  decode_pkg::data_t     exp_data  [MAX_INST];
  int                    commit_cnt [MAX_INST];
  decode_pkg::data_t     gold_regs [`NUM_REGS];

  int          prog_len = 0, n_directed = 0, n_legal = 0, n_commits = 0;
  int          value_errors = 0, commit_errors = 0;
  int          cycle_count = 0, timeout_limit = 40 * MAX_INST;
  logic [31:0] rnd;

  tb_clock u_clock (.clk(clk));

  decode_issue_top u_dut (.*);

  //------------------------------------------------------------
  // Encoders, random source and reference model
  //------------------------------------------------------------

  function automatic decode_pkg::inst_t op_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic decode_pkg::inst_t op_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic decode_pkg::inst_t add_word(input logic [4:0] rd, rs1, rs2);
    return op_r(7'h00, rs2, rs1, 3'b000, rd, 7'b0110011);
  endfunction

  function automatic decode_pkg::inst_t mul_word(input logic [4:0] rd, rs1, rs2);
    return op_r(7'h01, rs2, rs1, 3'b000, rd, 7'b0110011);
  endfunction

  function automatic decode_pkg::inst_t addi_word(input logic [4:0] rd, rs1,
                                                  input logic [11:0] imm);
    return op_i(imm, rs1, 3'b000, rd, 7'b0010011);
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Executes one word against the golden registers in program order
  function automatic void ref_exec(input decode_pkg::inst_t w, output bit legal,
                                   output decode_pkg::data_t val);
    decode_pkg::data_t a, b, imm;
    a     = gold_regs[w[19:15]];
    b     = gold_regs[w[24:20]];
    imm   = $signed(w[31:20]);
    legal = 1'b1;
    val   = '0;
    if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
      val = a + b;
    end else if (w[6:0] == 7'b0110011 && w[14:12] == 3'b000 && w[31:25] == 7'h01) begin
      val = a * b;
    end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
      val = a + imm;
    end else begin
      legal = 1'b0;
    end
  endfunction

  task automatic append_inst(input decode_pkg::inst_t w);
    bit                legal;
    decode_pkg::data_t val;
    ref_exec(w, legal, val);
    prog[prog_len]      = w;
    exp_legal[prog_len] = legal;
    exp_waddr[prog_len] = w[11:7];
    exp_data[prog_len]  = val;
    if (legal) n_legal++;
    if (legal && w[11:7] != 5'd0) gold_regs[w[11:7]] = val;
    prog_len++;
  endtask

  task automatic build_program();
    // Immediates 10, 2047 and -1 followed by a dependent chain with wrapping products
    append_inst(addi_word(5'd1, 5'd0, 12'd10));
    append_inst(addi_word(5'd2, 5'd0, 12'd2047));
    append_inst(addi_word(5'd3, 5'd0, 12'hfff));
    append_inst(add_word(5'd4, 5'd1, 5'd2));
    append_inst(mul_word(5'd5, 5'd4, 5'd3));
    append_inst(mul_word(5'd6, 5'd2, 5'd2));
    append_inst(mul_word(5'd7, 5'd6, 5'd6));
    append_inst(add_word(5'd8, 5'd7, 5'd5));
    // x0 as destination and then as source
    append_inst(addi_word(5'd0, 5'd1, 12'd5));
    append_inst(add_word(5'd0, 5'd2, 5'd2));
    append_inst(add_word(5'd10, 5'd0, 5'd1));
    // Independent mul and add mix that may commit out of order
    append_inst(mul_word(5'd12, 5'd1, 5'd2));
    append_inst(add_word(5'd13, 5'd1, 5'd1));
    append_inst(mul_word(5'd14, 5'd3, 5'd3));
    append_inst(addi_word(5'd15, 5'd2, 12'h800));
    // lw, bne, sub and garbage around legal work
    append_inst(op_i(12'd4, 5'd1, 3'b010, 5'd17, 7'b0000011));
    append_inst(addi_word(5'd18, 5'd1, 12'd1));
    append_inst(op_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd0, 7'b1100011));
    append_inst(op_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd19, 7'b0110011));
    append_inst(32'hffff_ffff);
    append_inst(add_word(5'd20, 5'd18, 5'd17));
    n_directed = prog_len;
    for (int i = 0; i < N_RANDOM; i++) begin
      rnd = xorshift32(rnd);
      case (rnd[2:0])
        3'd0, 3'd1, 3'd2: append_inst(add_word({1'b0, rnd[7:4]}, {1'b0, rnd[11:8]},
                                               {1'b0, rnd[15:12]}));
        3'd3, 3'd4:       append_inst(addi_word({1'b0, rnd[7:4]}, {1'b0, rnd[11:8]},
                                                rnd[27:16]));
        3'd5, 3'd6:       append_inst(mul_word({1'b0, rnd[7:4]}, {1'b0, rnd[11:8]},
                                               {1'b0, rnd[15:12]}));
        default:          append_inst({rnd[31:7], 7'b0000011});
      endcase
    end
  endtask

  //------------------------------------------------------------
  // Stimulus driven on the falling edge
  //------------------------------------------------------------

  task automatic send_range(input int first, input int last, input bit noisy);
    int idx;
    bit offering;
    idx      = first;
    offering = 1'b0;
    while (idx < last) begin
      @(negedge clk);
      rnd        = xorshift32(rnd);
      commit_rdy = noisy ? (rnd[1:0] != 2'b00) : 1'b1;
      // A bubble only while nothing is on offer
      if (!offering && noisy && rnd[3:2] == 2'b00) begin
        inst_val = 1'b0;
      end else begin
        inst_val = 1'b1;
        inst_pc  = PC_BASE + 32'(4 * idx);
        inst     = prog[idx];
      end
      #1;
      offering = inst_val & ~inst_rdy;
      if (inst_val && inst_rdy) idx++;
    end
    @(negedge clk);
    inst_val = 1'b0;
  endtask

  task automatic drain();
    while (n_commits < n_legal) begin
      @(negedge clk);
      commit_rdy = 1'b1;
    end
    // Room for a late duplicate to show up
    repeat (20) @(negedge clk);
  endtask

  initial begin : main
    rst        = 1'b1;
    inst_val   = 1'b0;
    inst_pc    = '0;
    inst       = '0;
    commit_rdy = 1'b1;
    rnd        = SEED;
    for (int i = 0; i < `NUM_REGS; i++) gold_regs[i] = '0;
    for (int i = 0; i < MAX_INST; i++) commit_cnt[i] = 0;
    build_program();
    timeout_limit = 40 * prog_len;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    send_range(0, n_directed, 1'b0);
    send_range(n_directed, prog_len, 1'b1);
    drain();
    for (int i = 0; i < prog_len; i++) begin
      if (exp_legal[i]) begin
        assert (commit_cnt[i] == 1) else begin
          commit_errors++;
          $display("Instruction at pc %h committed %0d times", PC_BASE + 32'(4 * i),
                   commit_cnt[i]);
        end
      end
    end
    $display("Summary: %0d value errors, %0d commit errors, %0d commits",
             value_errors, commit_errors, n_commits);
    if (value_errors == 0 && commit_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  //------------------------------------------------------------
  // Commit checker and timeout
  //------------------------------------------------------------

  // Sampled mid low phase ahead of the rising edge that transfers
  initial begin : commit_check
    int k;
    bit known;
    forever begin
      @(negedge clk);
      #2;
      if (!rst && commit_val && commit_rdy) begin
        n_commits++;
        known = commit_pc >= PC_BASE && commit_pc < PC_BASE + 32'(4 * prog_len)
                && commit_pc[1:0] == 2'b00;
        assert (known) else begin
          commit_errors++;
          $display("Commit from a pc that was never sent, pc %h", commit_pc);
        end
        if (known) begin
          k = int'((commit_pc - PC_BASE) >> 2);
          assert (exp_legal[k] && commit_cnt[k] == 0) else begin
            commit_errors++;
            $display("Unexpected or repeated commit at pc %h", commit_pc);
          end
          assert (commit_waddr == exp_waddr[k]) else begin
            value_errors++;
            $display("[ERROR] commit_waddr pc %h: got %h, expected %h",
                     commit_pc, commit_waddr, exp_waddr[k]);
          end
          assert (commit_data == exp_data[k]) else begin
            value_errors++;
            $display("[ERROR] commit_data pc %h: got %h, expected %h",
                     commit_pc, commit_data, exp_data[k]);
          end
          commit_cnt[k]++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout after %0d cycles, %0d of %0d results committed",
               cycle_count, n_commits, n_legal);
      $display("Summary: %0d value errors, %0d commit errors, %0d commits",
               value_errors, commit_errors, n_commits);
      $display("Test FAILED");
      $finish;
    end
  end

endmodule

// File: verification/tb_clock.sv
/*
 * Free-running testbench clock, 8 ns period
 */

`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD = 8.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

endmodule

// File: src/decode_issue_top.sv
/*
 * Decode and issue slice top level
 * Decoder, register file, ALU and MUL pipes, writeback stage
 */

`timescale 1ns/1ps
`include "decode_params.svh"

module decode_issue_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_val,
  output logic                  inst_rdy,
  input  decode_pkg::pc_t       inst_pc,
  input  decode_pkg::inst_t     inst,
  output logic                  commit_val,
  input  logic                  commit_rdy,
  output decode_pkg::pc_t       commit_pc,
  output decode_pkg::reg_addr_t commit_waddr,
  output decode_pkg::data_t     commit_data
);

  //------------------------------------------------------------
  // Interconnect
  //------------------------------------------------------------

  decode_pkg::reg_addr_t rs1_addr, rs2_addr;
  decode_pkg::data_t     rs1_data, rs2_data;
  logic                  alu_val, alu_rdy, mul_val, mul_rdy;
  decode_pkg::pc_t       x_pc;
  decode_pkg::data_t     x_op1, x_op2;
  decode_pkg::reg_addr_t x_waddr;
  logic                  alu_res_val, alu_res_rdy, mul_res_val, mul_res_rdy;
  decode_pkg::pc_t       alu_res_pc, mul_res_pc;
  decode_pkg::reg_addr_t alu_res_waddr, mul_res_waddr;
  decode_pkg::data_t     alu_res_data, mul_res_data;
  logic                  wb_en;
  decode_pkg::reg_addr_t wb_addr;
  decode_pkg::data_t     wb_data;

  //------------------------------------------------------------
  // Instances
  //------------------------------------------------------------

  decode_basic u_decode (.*);

  reg_file u_reg_file (.*);

  alu_pipe u_alu_pipe (.*);

  mul_pipe #(
    .STAGES (`MUL_STAGES)
  ) u_mul_pipe (.*);

  writeback_arbiter u_writeback (.*);

endmodule

// File: src/writeback_arbiter.sv
/*
 * Writeback stage, fixed priority to the multiply pipe,
 * register file write pulse and one-entry commit register
 */

`timescale 1ns/1ps

module writeback_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  alu_res_val,
  output logic                  alu_res_rdy,
  input  decode_pkg::pc_t       alu_res_pc,
  input  decode_pkg::reg_addr_t alu_res_waddr,
  input  decode_pkg::data_t     alu_res_data,
  input  logic                  mul_res_val,
  output logic                  mul_res_rdy,
  input  decode_pkg::pc_t       mul_res_pc,
  input  decode_pkg::reg_addr_t mul_res_waddr,
  input  decode_pkg::data_t     mul_res_data,
  output logic                  wb_en,
  output decode_pkg::reg_addr_t wb_addr,
  output decode_pkg::data_t     wb_data,
  output logic                  commit_val,
  input  logic                  commit_rdy,
  output decode_pkg::pc_t       commit_pc,
  output decode_pkg::reg_addr_t commit_waddr,
  output decode_pkg::data_t     commit_data
);

  logic            can_load;
  decode_pkg::pc_t sel_pc;

  assign can_load = ~commit_val | commit_rdy;

  // ALU waits while the MUL pipe offers a product
  assign mul_res_rdy = can_load;
  assign alu_res_rdy = can_load & ~mul_res_val;

  assign wb_en   = can_load & (mul_res_val | alu_res_val);
  assign wb_addr = mul_res_val ? mul_res_waddr : alu_res_waddr;
  assign wb_data = mul_res_val ? mul_res_data : alu_res_data;
  assign sel_pc  = mul_res_val ? mul_res_pc : alu_res_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      commit_val <= 1'b0;
    end else if (wb_en) begin
      commit_val <= 1'b1;
    end else if (commit_rdy) begin
      commit_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_en) begin
      commit_pc    <= sel_pc;
      commit_waddr <= wb_addr;
      commit_data  <= wb_data;
    end
  end

endmodule

// File: src/mul_pipe.sv
/*
 * Pipelined multiplier, STAGES valid-tagged registers,
 * whole pipe freezes while the last stage is blocked
 */

`timescale 1ns/1ps

module mul_pipe #(
  parameter int STAGES = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  mul_val,
  output logic                  mul_rdy,
  input  decode_pkg::pc_t       x_pc,
  input  decode_pkg::data_t     x_op1,
  input  decode_pkg::data_t     x_op2,
  input  decode_pkg::reg_addr_t x_waddr,
  output logic                  mul_res_val,
  input  logic                  mul_res_rdy,
  output decode_pkg::pc_t       mul_res_pc,
  output decode_pkg::reg_addr_t mul_res_waddr,
  output decode_pkg::data_t     mul_res_data
);

  logic                  shift_en;
  logic                  stage_val   [STAGES];
  decode_pkg::pc_t       stage_pc    [STAGES];
  decode_pkg::reg_addr_t stage_waddr [STAGES];
  decode_pkg::data_t     stage_data  [STAGES];

  // Advance unless the tail holds a result nobody takes
  assign shift_en = ~(stage_val[STAGES-1] & ~mul_res_rdy);
  assign mul_rdy  = shift_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < STAGES; i++) begin
        stage_val[i] <= 1'b0;
      end
    end else if (shift_en) begin
      stage_val[0] <= mul_val;
      for (int i = 1; i < STAGES; i++) begin
        stage_val[i] <= stage_val[i-1];
      end
    end
  end

  // Low half of the product enters stage 0
  always_ff @(posedge clk) begin
    if (shift_en) begin
      stage_pc[0]    <= x_pc;
      stage_waddr[0] <= x_waddr;
      stage_data[0]  <= x_op1 * x_op2;
      for (int i = 1; i < STAGES; i++) begin
        stage_pc[i]    <= stage_pc[i-1];
        stage_waddr[i] <= stage_waddr[i-1];
        stage_data[i]  <= stage_data[i-1];
      end
    end
  end

  assign mul_res_val   = stage_val[STAGES-1];
  assign mul_res_pc    = stage_pc[STAGES-1];
  assign mul_res_waddr = stage_waddr[STAGES-1];
  assign mul_res_data  = stage_data[STAGES-1];

endmodule

// File: src/alu_pipe.sv
/*
 * Single-stage adder pipe with a one-entry result register
 */

`timescale 1ns/1ps

module alu_pipe (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  alu_val,
  output logic                  alu_rdy,
  input  decode_pkg::pc_t       x_pc,
  input  decode_pkg::data_t     x_op1,
  input  decode_pkg::data_t     x_op2,
  input  decode_pkg::reg_addr_t x_waddr,
  output logic                  alu_res_val,
  input  logic                  alu_res_rdy,
  output decode_pkg::pc_t       alu_res_pc,
  output decode_pkg::reg_addr_t alu_res_waddr,
  output decode_pkg::data_t     alu_res_data
);

  logic load;

  // Room when the result register is empty or leaving this cycle
  assign alu_rdy = ~alu_res_val | alu_res_rdy;
  assign load    = alu_val & alu_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_res_val <= 1'b0;
    end else if (load) begin
      alu_res_val <= 1'b1;
    end else if (alu_res_rdy) begin
      alu_res_val <= 1'b0;
    end
  end

  // Sum wraps at the data width
  always_ff @(posedge clk) begin
    if (load) begin
      alu_res_pc    <= x_pc;
      alu_res_waddr <= x_waddr;
      alu_res_data  <= x_op1 + x_op2;
    end
  end

endmodule

// File: src/reg_file.sv
/*
 * Architectural register file, two combinational read ports,
 * one write port, x0 reads as zero
 */

`timescale 1ns/1ps
`include "decode_params.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  decode_pkg::reg_addr_t rs1_addr,
  input  decode_pkg::reg_addr_t rs2_addr,
  output decode_pkg::data_t     rs1_data,
  output decode_pkg::data_t     rs2_data,
  input  logic                  wb_en,
  input  decode_pkg::reg_addr_t wb_addr,
  input  decode_pkg::data_t     wb_data
);

  decode_pkg::data_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_addr != '0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // Register 0 is never written
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

// File: src/decode_basic.sv
/*
 * Instruction decode for add, addi and mul, scoreboard of pending writes,
 * operand read and a one-entry issue register steering to ALU or MUL pipe
 */

`timescale 1ns/1ps
`include "decode_params.svh"

module decode_basic (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_val,
  output logic                  inst_rdy,
  input  decode_pkg::pc_t       inst_pc,
  input  decode_pkg::inst_t     inst,
  output decode_pkg::reg_addr_t rs1_addr,
  output decode_pkg::reg_addr_t rs2_addr,
  input  decode_pkg::data_t     rs1_data,
  input  decode_pkg::data_t     rs2_data,
  output logic                  alu_val,
  input  logic                  alu_rdy,
  output logic                  mul_val,
  input  logic                  mul_rdy,
  output decode_pkg::pc_t       x_pc,
  output decode_pkg::data_t     x_op1,
  output decode_pkg::data_t     x_op2,
  output decode_pkg::reg_addr_t x_waddr,
  input  logic                  wb_en,
  input  decode_pkg::reg_addr_t wb_addr
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  decode_pkg::reg_addr_t    rd;
  decode_pkg::uop_t         dec_uop;
  logic                     uses_rs2;
  logic                     is_imm;
  decode_pkg::data_t        imm_i;
  logic                     legal;
  logic                     hazard;
  logic                     can_take;
  logic                     issue_drain;
  logic                     issue_load;
  logic [`NUM_REGS-1:0]     sb;
  decode_pkg::issue_state_t state;
  decode_pkg::uop_t         x_uop;

  //------------------------------------------------------------
  // Field extraction and decode
  //------------------------------------------------------------

  assign opcode   = inst[6:0];
  assign rd       = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];
  assign funct7   = inst[31:25];

  // I-type immediate, sign extended
  assign imm_i  = {{(`DATA_W-12){inst[31]}}, inst[31:20]};
  assign is_imm = (opcode == OPC_OP_IMM);

  always_comb begin
    dec_uop  = decode_pkg::UOP_ILLEGAL;
    uses_rs2 = 1'b0;
    if (opcode == OPC_OP && funct3 == 3'b000) begin
      if (funct7 == 7'b0000000) begin
        dec_uop  = decode_pkg::UOP_ADD;
        uses_rs2 = 1'b1;
      end else if (funct7 == 7'b0000001) begin
        dec_uop  = decode_pkg::UOP_MUL;
        uses_rs2 = 1'b1;
      end
    end else if (is_imm && funct3 == 3'b000) begin
      dec_uop = decode_pkg::UOP_ADD;
    end
  end

  assign legal = (dec_uop != decode_pkg::UOP_ILLEGAL);

  //------------------------------------------------------------
  // Hazard check and fetch handshake
  //------------------------------------------------------------

  // x0 never has its bit set, so it never stalls
  assign hazard = sb[rs1_addr] | (uses_rs2 & sb[rs2_addr]) | sb[rd];

  assign issue_drain = (alu_val & alu_rdy) | (mul_val & mul_rdy);
  assign can_take    = (state == decode_pkg::ISSUE_EMPTY) | issue_drain;

  // Illegal words are taken whenever there is room and then dropped
  assign inst_rdy   = can_take & (~legal | ~hazard);
  assign issue_load = inst_val & inst_rdy & legal;

  always_ff @(posedge clk) begin
    if (rst) begin
      sb <= '0;
    end else begin
      if (wb_en) begin
        sb[wb_addr] <= 1'b0;
      end
      if (issue_load && rd != '0) begin
        sb[rd] <= 1'b1;
      end
    end
  end

  //------------------------------------------------------------
  // Issue register
  //------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= decode_pkg::ISSUE_EMPTY;
    end else if (issue_load) begin
      state <= decode_pkg::ISSUE_FULL;
    end else if (issue_drain) begin
      state <= decode_pkg::ISSUE_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_load) begin
      x_uop   <= dec_uop;
      x_pc    <= inst_pc;
      x_op1   <= rs1_data;
      x_op2   <= is_imm ? imm_i : rs2_data;
      x_waddr <= rd;
    end
  end

  // Steering by micro-op
  assign alu_val = (state == decode_pkg::ISSUE_FULL) & (x_uop == decode_pkg::UOP_ADD);
  assign mul_val = (state == decode_pkg::ISSUE_FULL) & (x_uop == decode_pkg::UOP_MUL);

endmodule

// File: src/decode_pkg.sv
/*
 * Shared types for the decode and issue slice
 * Vector typedefs, micro-op enum, issue register state enum
 */

`include "decode_params.svh"

package decode_pkg;

  //------------------------------------------------------------
  // Vector types
  //------------------------------------------------------------

  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`ADDR_W-1:0] pc_t;
  typedef logic [31:0]        inst_t;
  typedef logic [4:0]         reg_addr_t;

  //------------------------------------------------------------
  // Enums
  //------------------------------------------------------------

  // addi folds into UOP_ADD with the immediate as op2
  typedef enum logic [1:0] {
    UOP_ADD,
    UOP_MUL,
    UOP_ILLEGAL
  } uop_t;

  // Decoder output register occupancy
  typedef enum logic {
    ISSUE_EMPTY,
    ISSUE_FULL
  } issue_state_t;

endpackage

// File: include/decode_params.svh
/*
 * Width and size macros for the decode and issue slice
 */

`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Operand and result width
`define DATA_W 32

// Program counter width
`define ADDR_W 32

// Architectural registers and multiply pipe depth
`define NUM_REGS 32
`define MUL_STAGES 3

`endif
